// ==== design/cop0_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module cop0_decode import decoder_pkg::*; (
        input  wire [INSTR_W-1:0]     instruction,
        output logic                  hit,
        output logic                  undefined,
        output alu_op_e               alu_op,
        output alu_src_e              alu_src,
        output logic                  alu_imm_src,
        output mem_type_e             mem_type,
        output mem_size_e             mem_size,
        output logic [REG_ADDR_W-1:0] wb_reg_dest,
        output logic                  wb_reg_en,
        output logic                  unsigned_flag,
        output logic                  priv_inst
);

        logic [REG_ADDR_W-1:0] rs;

        assign rs  = instruction[25:21];
        assign hit = (instruction[31:26] == OP_COP0);

        assign alu_src       = SRC_REG;
        assign alu_imm_src   = SIGN_EXT;
        assign mem_type      = MEM_NOOP;
        assign mem_size      = SZ_FULL;
        assign wb_reg_dest   = instruction[20:16]; // rt
        assign unsigned_flag = ZERO_EXT;
        assign priv_inst     = hit;

        always_comb begin
                alu_op    = ADDU;
                wb_reg_en = 1'b0;
                undefined = 1'b0;
                if (instruction == ERET_WORD) begin
                        alu_op = ERET;
                end else if (rs == COP0_MF) begin
                        alu_op    = MFC0;
                        wb_reg_en = 1'b1; // Only MFC0 returns a value
                end else if (rs == COP0_MT) begin
                        alu_op = MTC0;
                end else begin
                        undefined = hit;
                end
        end

endmodule

`default_nettype wire

// ==== design/ctrl_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctrl_reg import decoder_pkg::*; (
        input  wire                   clk,
        input  wire                   rst_n,
        input  wire                   in_valid,
        output logic                  in_ready,
        output logic                  out_valid,
        input  wire                   out_ready,
        input  wire                   dec_undefined,
        input  wire alu_op_e          dec_alu_op,
        input  wire alu_src_e         dec_alu_src,
        input  wire                   dec_alu_imm_src,
        input  wire mem_type_e        dec_mem_type,
        input  wire mem_size_e        dec_mem_size,
        input  wire [REG_ADDR_W-1:0]  dec_wb_reg_dest,
        input  wire                   dec_wb_reg_en,
        input  wire                   dec_unsigned_flag,
        input  wire                   dec_priv_inst,
        output logic                  undefined,
        output alu_op_e               alu_op,
        output alu_src_e              alu_src,
        output logic                  alu_imm_src,
        output mem_type_e             mem_type,
        output mem_size_e             mem_size,
        output logic [REG_ADDR_W-1:0] wb_reg_dest,
        output logic                  wb_reg_en,
        output logic                  unsigned_flag,
        output logic                  priv_inst
);

        assign in_ready = !out_valid || out_ready; // Free slot or it drains this edge

        always_ff @(posedge clk) begin
                if (!rst_n)
                        out_valid <= 1'b0;
                else if (in_ready)
                        out_valid <= in_valid;
        end

        always_ff @(posedge clk) begin
                if (in_valid && in_ready) begin
                        undefined     <= dec_undefined;
                        alu_op        <= dec_alu_op;
                        alu_src       <= dec_alu_src;
                        alu_imm_src   <= dec_alu_imm_src;
                        mem_type      <= dec_mem_type;
                        mem_size      <= dec_mem_size;
                        wb_reg_dest   <= dec_wb_reg_dest;
                        wb_reg_en     <= dec_wb_reg_en;
                        unsigned_flag <= dec_unsigned_flag;
                        priv_inst     <= dec_priv_inst;
                end
        end

        a_payload_hold: assert property (@(posedge clk) disable iff (!rst_n)
                out_valid && !out_ready |=> $stable({undefined, alu_op, alu_src, alu_imm_src,
                        mem_type, mem_size, wb_reg_dest, wb_reg_en, unsigned_flag, priv_inst}));

        a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
                out_valid && !out_ready |=> out_valid);

        // Nothing may leave before the first accepted word
        a_reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid);

endmodule

`default_nettype wire

// ==== design/decoder_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module decoder_ctrl import decoder_pkg::*; (
        input  wire                   clk,
        input  wire                   rst_n,
        input  wire [INSTR_W-1:0]     instruction,
        input  wire                   is_branch,
        input  wire                   is_branch_al,
        input  wire                   in_valid,
        output logic                  in_ready,
        output logic                  out_valid,
        input  wire                   out_ready,
        output logic                  undefined,
        output alu_op_e               alu_op,
        output alu_src_e              alu_src,
        output logic                  alu_imm_src,
        output mem_type_e             mem_type,
        output mem_size_e             mem_size,
        output logic [REG_ADDR_W-1:0] wb_reg_dest,
        output logic                  wb_reg_en,
        output logic                  unsigned_flag,
        output logic                  priv_inst
);

        logic                  sp_hit, im_hit, c0_hit, c0_undefined, sel_undefined;
        alu_op_e               sp_alu_op, im_alu_op, c0_alu_op, sel_alu_op;
        alu_src_e              sp_alu_src, im_alu_src, c0_alu_src, sel_alu_src;
        logic                  sp_alu_imm_src, im_alu_imm_src, c0_alu_imm_src, sel_alu_imm_src;
        mem_type_e             sp_mem_type, im_mem_type, c0_mem_type, sel_mem_type;
        mem_size_e             sp_mem_size, im_mem_size, c0_mem_size, sel_mem_size;
        logic [REG_ADDR_W-1:0] sp_wb_reg_dest, im_wb_reg_dest, c0_wb_reg_dest, sel_wb_reg_dest;
        logic                  sp_wb_reg_en, im_wb_reg_en, c0_wb_reg_en, sel_wb_reg_en;
        logic                  sp_unsigned_flag, im_unsigned_flag, c0_unsigned_flag, sel_unsigned_flag;
        logic                  sp_priv_inst, im_priv_inst, c0_priv_inst, sel_priv_inst;

        special_decode i_special (
                .instruction(instruction), .hit(sp_hit),
                .alu_op(sp_alu_op), .alu_src(sp_alu_src), .alu_imm_src(sp_alu_imm_src),
                .mem_type(sp_mem_type), .mem_size(sp_mem_size), .wb_reg_dest(sp_wb_reg_dest),
                .wb_reg_en(sp_wb_reg_en), .unsigned_flag(sp_unsigned_flag), .priv_inst(sp_priv_inst)
        );

        imm_decode i_imm (
                .instruction(instruction), .hit(im_hit),
                .alu_op(im_alu_op), .alu_src(im_alu_src), .alu_imm_src(im_alu_imm_src),
                .mem_type(im_mem_type), .mem_size(im_mem_size), .wb_reg_dest(im_wb_reg_dest),
                .wb_reg_en(im_wb_reg_en), .unsigned_flag(im_unsigned_flag), .priv_inst(im_priv_inst)
        );

        cop0_decode i_cop0 (
                .instruction(instruction), .hit(c0_hit), .undefined(c0_undefined),
                .alu_op(c0_alu_op), .alu_src(c0_alu_src), .alu_imm_src(c0_alu_imm_src),
                .mem_type(c0_mem_type), .mem_size(c0_mem_size), .wb_reg_dest(c0_wb_reg_dest),
                .wb_reg_en(c0_wb_reg_en), .unsigned_flag(c0_unsigned_flag), .priv_inst(c0_priv_inst)
        );

        always_comb begin
                sel_alu_op        = ADDU; // Fallback unless a table claims the word
                sel_alu_src       = SRC_REG;
                sel_alu_imm_src   = SIGN_EXT;
                sel_mem_type      = MEM_NOOP;
                sel_mem_size      = SZ_FULL;
                sel_wb_reg_dest   = instruction[20:16];
                sel_wb_reg_en     = 1'b0;
                sel_unsigned_flag = ZERO_EXT;
                sel_priv_inst     = 1'b0;
                sel_undefined     = !is_branch; // A plain branch is still legal
                if (is_branch && is_branch_al) begin
                        sel_alu_op      = OUTA; // Pass the return address through
                        sel_alu_src     = SRC_PCA;
                        sel_wb_reg_dest = LINK_REG;
                        sel_wb_reg_en   = 1'b1;
                end
                if (sp_hit) begin
                        sel_alu_op        = sp_alu_op;
                        sel_alu_src       = sp_alu_src;
                        sel_alu_imm_src   = sp_alu_imm_src;
                        sel_mem_type      = sp_mem_type;
                        sel_mem_size      = sp_mem_size;
                        sel_wb_reg_dest   = sp_wb_reg_dest;
                        sel_wb_reg_en     = sp_wb_reg_en;
                        sel_unsigned_flag = sp_unsigned_flag;
                        sel_priv_inst     = sp_priv_inst;
                        sel_undefined     = 1'b0;
                end else if (im_hit) begin
                        sel_alu_op        = im_alu_op;
                        sel_alu_src       = im_alu_src;
                        sel_alu_imm_src   = im_alu_imm_src;
                        sel_mem_type      = im_mem_type;
                        sel_mem_size      = im_mem_size;
                        sel_wb_reg_dest   = im_wb_reg_dest;
                        sel_wb_reg_en     = im_wb_reg_en;
                        sel_unsigned_flag = im_unsigned_flag;
                        sel_priv_inst     = im_priv_inst;
                        sel_undefined     = 1'b0;
                end else if (c0_hit) begin
                        sel_alu_op        = c0_alu_op;
                        sel_alu_src       = c0_alu_src;
                        sel_alu_imm_src   = c0_alu_imm_src;
                        sel_mem_type      = c0_mem_type;
                        sel_mem_size      = c0_mem_size;
                        sel_wb_reg_dest   = c0_wb_reg_dest;
                        sel_wb_reg_en     = c0_wb_reg_en;
                        sel_unsigned_flag = c0_unsigned_flag;
                        sel_priv_inst     = c0_priv_inst;
                        sel_undefined     = c0_undefined;
                end
        end

        ctrl_reg i_ctrl_reg (
                .clk(clk), .rst_n(rst_n),
                .in_valid(in_valid), .in_ready(in_ready),
                .out_valid(out_valid), .out_ready(out_ready),
                .dec_undefined(sel_undefined), .dec_alu_op(sel_alu_op),
                .dec_alu_src(sel_alu_src), .dec_alu_imm_src(sel_alu_imm_src),
                .dec_mem_type(sel_mem_type), .dec_mem_size(sel_mem_size),
                .dec_wb_reg_dest(sel_wb_reg_dest), .dec_wb_reg_en(sel_wb_reg_en),
                .dec_unsigned_flag(sel_unsigned_flag), .dec_priv_inst(sel_priv_inst),
                .undefined(undefined), .alu_op(alu_op), .alu_src(alu_src),
                .alu_imm_src(alu_imm_src), .mem_type(mem_type), .mem_size(mem_size),
                .wb_reg_dest(wb_reg_dest), .wb_reg_en(wb_reg_en),
                .unsigned_flag(unsigned_flag), .priv_inst(priv_inst)
        );

endmodule

`default_nettype wire

// ==== design/decoder_pkg.sv ====
`default_nettype none

package decoder_pkg;

        localparam int INSTR_W    = 32;
        localparam int REG_ADDR_W = 5;

        localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31; // $ra

        localparam logic [INSTR_W-1:0]    ERET_WORD = 32'h4200_0018;
        localparam logic [REG_ADDR_W-1:0] COP0_MF   = 5'b00000; // rs field selects the move
        localparam logic [REG_ADDR_W-1:0] COP0_MT   = 5'b00100;

        // Shared by alu_imm_src and unsigned_flag
        localparam logic SIGN_EXT = 1'b0;
        localparam logic ZERO_EXT = 1'b1;

        typedef enum logic [5:0] {
                ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR, LUI,
                SLL, SRL, SRA, MULT, MULTU, DIV, DIVU, MFHI, MFLO, MTHI, MTLO,
                BREK, SYSC, ERET, MFC0, MTC0, OUTA
        } alu_op_e;

        typedef enum logic [1:0] {
                SRC_REG = 2'd0, // rt
                SRC_IMM = 2'd1,
                SRC_SFT = 2'd2, // shamt
                SRC_PCA = 2'd3  // Link address
        } alu_src_e;

        typedef enum logic [1:0] {
                MEM_NOOP = 2'd0,
                MEM_LOAD = 2'd1,
                MEM_STOR = 2'd2
        } mem_type_e;

        typedef enum logic [2:0] {
                SZ_BYTE = 3'd0,
                SZ_HALF = 3'd1,
                SZ_FULL = 3'd2
        } mem_size_e;

        typedef enum logic [5:0] {
                OP_SPECIAL = 6'b000000, OP_COP0  = 6'b010000,
                OP_ADDI    = 6'b001000, OP_ADDIU = 6'b001001,
                OP_SLTI    = 6'b001010, OP_SLTIU = 6'b001011,
                OP_ANDI    = 6'b001100, OP_ORI   = 6'b001101,
                OP_XORI    = 6'b001110, OP_LUI   = 6'b001111,
                OP_LB      = 6'b100000, OP_LH    = 6'b100001,
                OP_LW      = 6'b100011, OP_LBU   = 6'b100100,
                OP_LHU     = 6'b100101, OP_SB    = 6'b101000,
                OP_SH      = 6'b101001, OP_SW    = 6'b101011
        } opcode_e;

        typedef enum logic [5:0] {
                F_SLL   = 6'b000000, F_SRL     = 6'b000010, F_SRA   = 6'b000011,
                F_SLLV  = 6'b000100, F_SRLV    = 6'b000110, F_SRAV  = 6'b000111,
                F_SYSC  = 6'b001100, F_BREAK   = 6'b001101,
                F_MFHI  = 6'b010000, F_MTHI    = 6'b010001,
                F_MFLO  = 6'b010010, F_MTLO    = 6'b010011,
                F_MULT  = 6'b011000, F_MULTU   = 6'b011001,
                F_DIV   = 6'b011010, F_DIVU    = 6'b011011,
                F_ADD   = 6'b100000, F_ADDU    = 6'b100001,
                F_SUB   = 6'b100010, F_SUBU    = 6'b100011,
                F_AND   = 6'b100100, F_OR      = 6'b100101,
                F_XOR   = 6'b100110, F_NOR     = 6'b100111,
                F_SLT   = 6'b101010, F_SLTU    = 6'b101011
        } funct_e;

endpackage

`default_nettype wire

// ==== design/imm_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module imm_decode import decoder_pkg::*; (
        input  wire [INSTR_W-1:0]     instruction,
        output logic                  hit,
        output alu_op_e               alu_op,
        output alu_src_e              alu_src,
        output logic                  alu_imm_src,
        output mem_type_e             mem_type,
        output mem_size_e             mem_size,
        output logic [REG_ADDR_W-1:0] wb_reg_dest,
        output logic                  wb_reg_en,
        output logic                  unsigned_flag,
        output logic                  priv_inst
);

        opcode_e opcode;

        assign opcode = opcode_e'(instruction[31:26]);

        assign alu_src       = SRC_IMM;
        assign wb_reg_dest   = instruction[20:16]; // rt
        assign wb_reg_en     = (mem_type != MEM_STOR);
        assign priv_inst     = 1'b0;
        assign alu_imm_src   = (opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) ? ZERO_EXT : SIGN_EXT;
        assign unsigned_flag = (opcode inside {OP_LB, OP_LH}) ? SIGN_EXT : ZERO_EXT;

        always_comb begin
                hit      = 1'b1;
                alu_op   = ADDU; // Loads and stores add base and offset
                mem_type = MEM_NOOP;
                mem_size = SZ_FULL;
                case (opcode)
                        OP_ADDI:                                alu_op = ADD;
                        OP_ADDIU:                               alu_op = ADDU;
                        OP_SLTI:                                alu_op = SLT;
                        OP_SLTIU:                               alu_op = SLTU;
                        OP_ANDI:                                alu_op = AND;
                        OP_ORI:                                 alu_op = OR;
                        OP_XORI:                                alu_op = XOR;
                        OP_LUI:                                 alu_op = LUI;
                        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW:    mem_type = MEM_LOAD;
                        OP_SB, OP_SH, OP_SW:                    mem_type = MEM_STOR;
                        default:                                hit = 1'b0;
                endcase
                if (opcode inside {OP_LB, OP_LBU, OP_SB})
                        mem_size = SZ_BYTE;
                else if (opcode inside {OP_LH, OP_LHU, OP_SH})
                        mem_size = SZ_HALF;
        end

endmodule

`default_nettype wire

// ==== design/special_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module special_decode import decoder_pkg::*; (
        input  wire [INSTR_W-1:0]     instruction,
        output logic                  hit,
        output alu_op_e               alu_op,
        output alu_src_e              alu_src,
        output logic                  alu_imm_src,
        output mem_type_e             mem_type,
        output mem_size_e             mem_size,
        output logic [REG_ADDR_W-1:0] wb_reg_dest,
        output logic                  wb_reg_en,
        output logic                  unsigned_flag,
        output logic                  priv_inst
);

        funct_e funct;

        assign funct = funct_e'(instruction[5:0]);

        assign alu_imm_src   = SIGN_EXT; // No immediate in R-type
        assign mem_type      = MEM_NOOP;
        assign mem_size      = SZ_FULL;
        assign wb_reg_dest   = instruction[15:11]; // rd
        assign unsigned_flag = ZERO_EXT;
        assign priv_inst     = funct inside {F_BREAK, F_SYSC};
        assign wb_reg_en     = !(funct inside {F_MULT, F_MULTU, F_DIV, F_DIVU,
                                               F_MTHI, F_MTLO});

        always_comb begin
                hit     = (instruction[31:26] == OP_SPECIAL);
                alu_op  = ADDU;
                alu_src = SRC_REG;
                case (funct)
                        F_ADD:          alu_op = ADD;
                        F_ADDU:         alu_op = ADDU;
                        F_SUB:          alu_op = SUB;
                        F_SUBU:         alu_op = SUBU;
                        F_SLT:          alu_op = SLT;
                        F_SLTU:         alu_op = SLTU;
                        F_AND:          alu_op = AND;
                        F_OR:           alu_op = OR;
                        F_XOR:          alu_op = XOR;
                        F_NOR:          alu_op = NOR;
                        F_SLL, F_SLLV:  alu_op = SLL;
                        F_SRL, F_SRLV:  alu_op = SRL;
                        F_SRA, F_SRAV:  alu_op = SRA;
                        F_MULT:         alu_op = MULT;
                        F_MULTU:        alu_op = MULTU;
                        F_DIV:          alu_op = DIV;
                        F_DIVU:         alu_op = DIVU;
                        F_MFHI:         alu_op = MFHI;
                        F_MFLO:         alu_op = MFLO;
                        F_MTHI:         alu_op = MTHI;
                        F_MTLO:         alu_op = MTLO;
                        F_BREAK:        alu_op = BREK;
                        F_SYSC:         alu_op = SYSC;
                        default:        hit = 1'b0; // Left to the fallback
                endcase
                if (funct inside {F_SLL, F_SRL, F_SRA})
                        alu_src = SRC_SFT; // Constant shifts take shamt
        end

endmodule

`default_nettype wire

// ==== mips_decode.f ====
+incdir+include
design/decoder_pkg.sv
design/special_decode.sv
design/imm_decode.sv
design/cop0_decode.sv
design/ctrl_reg.sv
design/decoder_ctrl.sv
verif/tb_decoder_ctrl.sv

// ==== include/decoder_model.svh ====
`ifndef DECODER_MODEL_SVH
`define DECODER_MODEL_SVH

typedef struct packed {
        logic                  undefined;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        logic                  alu_imm_src;
        mem_type_e             mem_type;
        mem_size_e             mem_size;
        logic [REG_ADDR_W-1:0] wb_reg_dest;
        logic                  wb_reg_en;
        logic                  unsigned_flag;
        logic                  priv_inst;
} ctrl_word_t;

// Expected control word from the MIPS32 encoding and the branch-unit hints
function automatic ctrl_word_t decode_ref(input logic [INSTR_W-1:0] instr,
                                          input logic br, input logic br_al);
        ctrl_word_t base;
        ctrl_word_t w;
        logic [5:0] op;
        logic [5:0] fn;
        logic       claimed;
        op   = instr[31:26];
        fn   = instr[5:0];
        base = '{undefined: 1'b0, alu_op: ADDU, alu_src: SRC_REG, alu_imm_src: SIGN_EXT,
                 mem_type: MEM_NOOP, mem_size: SZ_FULL, wb_reg_dest: instr[20:16],
                 wb_reg_en: 1'b0, unsigned_flag: ZERO_EXT, priv_inst: 1'b0};
        w       = base;
        claimed = 1'b1;
        if (op == OP_SPECIAL) begin
                w.wb_reg_dest = instr[15:11]; // rd
                w.wb_reg_en   = !(fn inside {F_MULT, F_MULTU, F_DIV, F_DIVU, F_MTHI, F_MTLO});
                w.priv_inst   = (fn inside {F_BREAK, F_SYSC});
                if (fn inside {F_SLL, F_SRL, F_SRA})
                        w.alu_src = SRC_SFT;
                case (fn)
                        F_ADD:          w.alu_op = ADD;
                        F_ADDU:         w.alu_op = ADDU;
                        F_SUB:          w.alu_op = SUB;
                        F_SUBU:         w.alu_op = SUBU;
                        F_SLT:          w.alu_op = SLT;
                        F_SLTU:         w.alu_op = SLTU;
                        F_AND:          w.alu_op = AND;
                        F_OR:           w.alu_op = OR;
                        F_XOR:          w.alu_op = XOR;
                        F_NOR:          w.alu_op = NOR;
                        F_SLL, F_SLLV:  w.alu_op = SLL;
                        F_SRL, F_SRLV:  w.alu_op = SRL;
                        F_SRA, F_SRAV:  w.alu_op = SRA;
                        F_MULT:         w.alu_op = MULT;
                        F_MULTU:        w.alu_op = MULTU;
                        F_DIV:          w.alu_op = DIV;
                        F_DIVU:         w.alu_op = DIVU;
                        F_MFHI:         w.alu_op = MFHI;
                        F_MFLO:         w.alu_op = MFLO;
                        F_MTHI:         w.alu_op = MTHI;
                        F_MTLO:         w.alu_op = MTLO;
                        F_BREAK:        w.alu_op = BREK;
                        F_SYSC:         w.alu_op = SYSC;
                        default:        claimed = 1'b0;
                endcase
        end else if (op == OP_COP0) begin
                w.priv_inst = 1'b1;
                if (instr == ERET_WORD) begin
                        w.alu_op = ERET;
                end else if (instr[25:21] == COP0_MF) begin
                        w.alu_op    = MFC0;
                        w.wb_reg_en = 1'b1;
                end else if (instr[25:21] == COP0_MT) begin
                        w.alu_op = MTC0;
                end else begin
                        w.undefined = 1'b1;
                end
        end else begin
                w.alu_src   = SRC_IMM;
                w.wb_reg_en = !(op inside {OP_SB, OP_SH, OP_SW});
                case (op)
                        OP_ADDI:        w.alu_op = ADD;
                        OP_ADDIU:       w.alu_op = ADDU;
                        OP_SLTI:        w.alu_op = SLT;
                        OP_SLTIU:       w.alu_op = SLTU;
                        OP_ANDI:        w.alu_op = AND;
                        OP_ORI:         w.alu_op = OR;
                        OP_XORI:        w.alu_op = XOR;
                        OP_LUI:         w.alu_op = LUI;
                        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW:    w.mem_type = MEM_LOAD;
                        OP_SB, OP_SH, OP_SW:                    w.mem_type = MEM_STOR;
                        default:        claimed = 1'b0;
                endcase
                if (op inside {OP_LB, OP_LBU, OP_SB})
                        w.mem_size = SZ_BYTE;
                if (op inside {OP_LH, OP_LHU, OP_SH})
                        w.mem_size = SZ_HALF;
                if (op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
                        w.alu_imm_src = ZERO_EXT;
                if (op inside {OP_LB, OP_LH})
                        w.unsigned_flag = SIGN_EXT;
        end
        if (!claimed) begin
                w           = base;
                w.undefined = !br;
                if (br && br_al) begin
                        w.alu_op      = OUTA; // Link address to $ra
                        w.alu_src     = SRC_PCA;
                        w.wb_reg_dest = LINK_REG;
                        w.wb_reg_en   = 1'b1;
                end
        end
        return w;
endfunction

`endif

// ==== verif/tb_decoder_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_decoder_ctrl import decoder_pkg::*; ();

        `include "decoder_model.svh"

        localparam int WAIT_LIMIT = 200;

        logic                  clk;
        logic                  rst_n;
        logic [INSTR_W-1:0]    instruction;
        logic                  is_branch;
        logic                  is_branch_al;
        logic                  in_valid;
        logic                  in_ready;
        logic                  out_valid;
        logic                  out_ready;
        logic                  undefined;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        logic                  alu_imm_src;
        mem_type_e             mem_type;
        mem_size_e             mem_size;
        logic [REG_ADDR_W-1:0] wb_reg_dest;
        logic                  wb_reg_en;
        logic                  unsigned_flag;
        logic                  priv_inst;

        ctrl_word_t exp_q[$];
        int         errors   = 0;
        int         checked  = 0;
        logic       stall_en = 1'b0;

        decoder_ctrl i_dut (.*);

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        task automatic check_field(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
                if (got !== want) begin
                        errors++;
                        $display("error %s got %h expected %h", name, got, want);
                end
        endtask

        task automatic abort_run(input string what);
                $display("timeout waiting for %s", what);
                $display("errors: %0d, words checked: %0d", errors + 1, checked);
                $display("TEST FAILED");
                $finish;
        endtask

        // Every negedge also redraws the consumer's ready
        task automatic next_negedge();
                @(negedge clk);
                out_ready = stall_en ? ($urandom % 4 != 0) : 1'b1;
        endtask

        task automatic send_word(input logic [INSTR_W-1:0] instr, input logic br,
                                 input logic br_al, input int gap);
                int waited;
                repeat (gap) begin
                        next_negedge();
                        in_valid    = 1'b0;
                        instruction = $urandom; // Idle bus content is ignored
                end
                next_negedge();
                in_valid     = 1'b1;
                instruction  = instr;
                is_branch    = br;
                is_branch_al = br_al;
                waited       = 0;
                @(posedge clk);
                while (!in_ready) begin
                        waited++;
                        if (waited > WAIT_LIMIT)
                                abort_run("in_ready");
                        next_negedge();
                        @(posedge clk);
                end
        endtask

        task automatic drain();
                int waited;
                next_negedge();
                in_valid = 1'b0;
                waited   = 0;
                while (exp_q.size() != 0) begin
                        waited++;
                        if (waited > WAIT_LIMIT)
                                abort_run("outstanding words to leave");
                        next_negedge();
                end
        endtask

        // Output side is checked before the same edge's input is queued
        always @(posedge clk) begin
                ctrl_word_t want;
                if (rst_n && out_valid && out_ready) begin
                        if (exp_q.size() == 0) begin
                                errors++;
                                $display("output transfer without a matching input");
                        end else begin
                                want = exp_q.pop_front();
                                checked++;
                                check_field("undefined", undefined, want.undefined);
                                check_field("alu_op", alu_op, want.alu_op);
                                check_field("alu_src", alu_src, want.alu_src);
                                check_field("alu_imm_src", alu_imm_src, want.alu_imm_src);
                                check_field("mem_type", mem_type, want.mem_type);
                                check_field("mem_size", mem_size, want.mem_size);
                                check_field("wb_reg_dest", wb_reg_dest, want.wb_reg_dest);
                                check_field("wb_reg_en", wb_reg_en, want.wb_reg_en);
                                check_field("unsigned_flag", unsigned_flag, want.unsigned_flag);
                                check_field("priv_inst", priv_inst, want.priv_inst);
                        end
                end
                if (rst_n && in_valid && in_ready)
                        exp_q.push_back(decode_ref(instruction, is_branch, is_branch_al));
        end

        initial begin
                logic [31:0]        r;
                logic [31:0]        h;
                logic [INSTR_W-1:0] instr;
                funct_e             fn;
                opcode_e            op;
                void'($urandom(32'he1944eef));
                rst_n        = 1'b0;
                in_valid     = 1'b0;
                out_ready    = 1'b1;
                instruction  = '0;
                is_branch    = 1'b0;
                is_branch_al = 1'b0;
                repeat (5) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                repeat (3) next_negedge();
                if (out_valid !== 1'b0) begin
                        errors++;
                        $display("out_valid is high after reset before any input was sent");
                end

                fn = fn.first();
                repeat (fn.num()) begin
                        r = $urandom;
                        send_word({OP_SPECIAL, r[25:6], fn}, 1'b0, 1'b0, 0);
                        fn = fn.next();
                end
                op = op.first();
                repeat (op.num()) begin
                        r = $urandom;
                        if (!(op inside {OP_SPECIAL, OP_COP0}))
                                send_word({op, r[25:0]}, 1'b0, 1'b0, 0);
                        op = op.next();
                end

                r = $urandom;
                send_word(ERET_WORD, 1'b0, 1'b0, 0);
                send_word({OP_COP0, COP0_MF, r[20:0]}, 1'b0, 1'b0, 0);
                send_word({OP_COP0, COP0_MT, r[20:0]}, 1'b0, 1'b0, 0);
                send_word({OP_COP0, 5'b00010, r[20:0]}, 1'b0, 1'b0, 0); // CFC0 is not decoded
                send_word({OP_COP0, 5'b10000, r[20:6], 6'b000001}, 1'b0, 1'b0, 0); // TLBR

                send_word({6'b000011, r[25:0]}, 1'b1, 1'b1, 0); // JAL
                send_word({6'b000011, r[25:0]}, 1'b0, 1'b1, 0);
                send_word({6'b000011, r[25:0]}, 1'b1, 1'b0, 0);
                send_word({OP_SPECIAL, r[25:6], 6'b001001}, 1'b1, 1'b1, 0); // JALR

                stall_en = 1'b1;
                repeat (400) begin
                        r  = $urandom;
                        h  = $urandom;
                        fn = fn.first();
                        repeat ($urandom % fn.num())
                                fn = fn.next();
                        op = op.first();
                        repeat ($urandom % op.num())
                                op = op.next();
                        case (h[1:0])
                                2'd0:    instr = {OP_SPECIAL, r[25:6], fn};
                                2'd1:    instr = {op, r[25:0]};
                                2'd2:    instr = {OP_COP0, r[25:0]};
                                default: instr = r;
                        endcase
                        send_word(instr, h[2], h[3], int'(h[5:4]));
                end
                drain();

                $display("errors: %0d, words checked: %0d", errors, checked);
                if (errors == 0)
                        $display("TEST PASSED");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

`default_nettype wire
